// File: include/nnWeights.svh
`ifndef NN_WEIGHTS_SVH
`define NN_WEIGHTS_SVH

// ========================================
// Hidden layer, numFeatures weights per neuron
// ========================================

// One unit is 1 << fracBits, so 256 is 1.0 at the default format
localparam nnPkg::hiddenWeightT hiddenWeights = {
	// Neuron 0
	16'sd320, -16'sd64, 16'sd192, 16'sd96,
	-16'sd128, 16'sd160, 16'sd256, -16'sd48,
	// Neuron 1, mostly negative so large inputs clip under ReLU
	-16'sd288, 16'sd112, -16'sd160, 16'sd144,
	16'sd64, -16'sd224, 16'sd32, -16'sd96,
	// Neuron 2
	16'sd176, 16'sd224, -16'sd96, -16'sd32,
	16'sd120, 16'sd72, -16'sd200, 16'sd40,
	// Neuron 3
	-16'sd56, -16'sd88, 16'sd136, 16'sd208,
	-16'sd24, 16'sd168, 16'sd104, -16'sd184
};

localparam nnPkg::hiddenBiasT hiddenBiases = {
	16'sd64, -16'sd32, 16'sd0, 16'sd96
};

// ========================================
// Score layer, numHidden weights per score
// ========================================

localparam nnPkg::scoreWeightT scoreWeights = {
	16'sd384, -16'sd160, 16'sd144, -16'sd80,  // Score 0
	-16'sd112, 16'sd288, -16'sd176, 16'sd224  // Score 1
};

localparam nnPkg::scoreBiasT scoreBiases = {
	-16'sd48, 16'sd80
};

`endif

// File: src/nnPkg.sv
package nnPkg;

	// ========================================
	// Number format
	// ========================================

	localparam int dataWidth = 16;
	localparam int fracBits = 8;                // Default, overridden from the top level
	localparam int prodWidth = 2 * dataWidth;   // Full width of one sample times weight
	localparam int accWidth = 40;               // Products plus growth for up to 256 terms

	// ========================================
	// Network shape and pipeline depth
	// ========================================

	localparam int numFeatures = 8;
	localparam int numHidden = 4;
	localparam int numScores = 2;

	// Input, product, sum and activation registers
	localparam int layerLatency = 4;
	localparam int netLatency = 2 * layerLatency;

	// ========================================
	// Types
	// ========================================

	typedef logic signed [dataWidth-1:0] sampleT;
	typedef logic signed [prodWidth-1:0] productT;
	typedef logic signed [accWidth-1:0] accT;

	// Limits used when clamping a rescaled sum back to a sample
	localparam sampleT sampleMax = {1'b0, {(dataWidth - 1){1'b1}}};
	localparam sampleT sampleMin = {1'b1, {(dataWidth - 1){1'b0}}};

	// Weight tables, neuron-major with element 0 leftmost
	typedef sampleT [0:numHidden*numFeatures-1] hiddenWeightT;
	typedef sampleT [0:numHidden-1] hiddenBiasT;
	typedef sampleT [0:numScores*numHidden-1] scoreWeightT;
	typedef sampleT [0:numScores-1] scoreBiasT;

endpackage

// File: src/macTree.sv
`timescale 1ns/1ps

module macTree #(
	parameter int NumInputs = nnPkg::numFeatures,
	parameter int FracBits = nnPkg::fracBits
) (
	input logic clk,
	input logic reset,
	input nnPkg::sampleT inputs [NumInputs],
	input nnPkg::sampleT [0:NumInputs-1] weights,
	input nnPkg::sampleT bias,
	output nnPkg::accT sum
);

	nnPkg::sampleT inReg [NumInputs];     // Cycle 1
	nnPkg::productT products [NumInputs]; // Cycle 2
	nnPkg::accT total;

	// ========================================
	// Input register
	// ========================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumInputs; i++)
				inReg[i] <= '0;
		end
		else
		begin
			inReg <= inputs;
		end
	end

	// ========================================
	// Products
	// ========================================

	// Each product keeps all 32 bits, the scaling happens after the sum
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumInputs; i++)
				products[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < NumInputs; i++)
				products[i] <= inReg[i] * weights[i];
		end
	end

	// ========================================
	// Accumulate
	// ========================================

	// Bias is lined up with the products, which carry 2*FracBits fraction bits
	always_comb
	begin
		total = nnPkg::accT'(bias) <<< FracBits;
		for (int i = 0; i < NumInputs; i++)
			total = total + nnPkg::accT'(products[i]);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sum <= '0;
		end
		else
		begin
			sum <= total; // Cycle 3
		end
	end

endmodule

// File: src/activation.sv
`timescale 1ns/1ps

module activation #(
	parameter int FracBits = nnPkg::fracBits,
	parameter bit UseRelu = 1'b1
) (
	input logic clk,
	input logic reset,
	input nnPkg::accT sum,
	output nnPkg::sampleT result
);

	nnPkg::accT shifted;
	nnPkg::sampleT clamped;
	nnPkg::sampleT activated;

	// Back to sample format, rounds toward minus infinity
	assign shifted = sum >>> FracBits;

	always_comb
	begin
		if (shifted > nnPkg::accT'(nnPkg::sampleMax))
			clamped = nnPkg::sampleMax;
		else if (shifted < nnPkg::accT'(nnPkg::sampleMin))
			clamped = nnPkg::sampleMin;
		else
			clamped = nnPkg::sampleT'(shifted);
	end

	// Output layer leaves the score linear
	assign activated = (UseRelu && clamped[nnPkg::dataWidth-1]) ? '0 : clamped;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result <= activated; // Cycle 4
		end
	end

endmodule

// File: src/denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumInputs = nnPkg::numFeatures,
	parameter int NumNeurons = nnPkg::numHidden,
	parameter int FracBits = nnPkg::fracBits,
	parameter bit UseRelu = 1'b1,
	parameter nnPkg::sampleT [0:NumNeurons*NumInputs-1] Weights = '0,
	parameter nnPkg::sampleT [0:NumNeurons-1] Biases = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::sampleT inputs [NumInputs],
	output nnPkg::sampleT outputs [NumNeurons]
);

	// ========================================
	// One neuron per output
	// ========================================

	for (genvar n = 0; n < NumNeurons; n++)
	begin : gNeuron
		nnPkg::accT neuronSum;

		// Row n of the table holds this neuron's weights
		macTree #(
			.NumInputs(NumInputs),
			.FracBits(FracBits)
		) mac (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.weights(Weights[n*NumInputs +: NumInputs]),
			.bias(Biases[n]),
			.sum(neuronSum)
		);

		activation #(
			.FracBits(FracBits),
			.UseRelu(UseRelu)
		) act (
			.clk(clk),
			.reset(reset),
			.sum(neuronSum),
			.result(outputs[n])
		);
	end

endmodule

// File: src/mlpTop.sv
`timescale 1ns/1ps

module mlpTop #(
	parameter int FracBits = nnPkg::fracBits
) (
	input logic clk,
	input logic reset,
	input nnPkg::sampleT features [nnPkg::numFeatures],
	output nnPkg::sampleT scores [nnPkg::numScores]
);

	`include "nnWeights.svh"

	nnPkg::sampleT hidden [nnPkg::numHidden];

	// Hidden layer with ReLU
	denseLayer #(
		.NumInputs(nnPkg::numFeatures),
		.NumNeurons(nnPkg::numHidden),
		.FracBits(FracBits),
		.UseRelu(1'b1),
		.Weights(hiddenWeights),
		.Biases(hiddenBiases)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.outputs(hidden)
	);

	// Linear scores
	denseLayer #(
		.NumInputs(nnPkg::numHidden),
		.NumNeurons(nnPkg::numScores),
		.FracBits(FracBits),
		.UseRelu(1'b0),
		.Weights(scoreWeights),
		.Biases(scoreBiases)
	) scoreLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hidden),
		.outputs(scores)
	);

endmodule

// File: tb/mlpTb.sv
`timescale 1ns/1ps

module mlpTb;

	localparam int FracBits = nnPkg::fracBits;
	localparam int drainTimeout = 4 * nnPkg::netLatency;
	localparam longint sampleHigh = (longint'(1) << (nnPkg::dataWidth - 1)) - 1;
	localparam longint sampleLow = -(longint'(1) << (nnPkg::dataWidth - 1));

	typedef nnPkg::sampleT [0:nnPkg::numFeatures-1] featurePackT;
	typedef nnPkg::sampleT [0:nnPkg::numHidden-1] hiddenPackT;
	typedef nnPkg::sampleT [0:nnPkg::numScores-1] scorePackT;

	// The DUT already pulled in the tables, so the guard is set
	`undef NN_WEIGHTS_SVH
	`include "nnWeights.svh"

	logic clk;
	logic reset;
	nnPkg::sampleT features [nnPkg::numFeatures];
	nnPkg::sampleT scores [nnPkg::numScores];

	featurePackT currentVector;
	string currentName;
	int seed;
	int pushCount;
	int lastChecked;
	bit resetSeen;
	int errorCount;

	scorePackT expectedLine [$]; // One entry per cycle, netLatency deep
	string nameLine [$];
	int serialLine [$];

	mlpTop #(
		.FracBits(FracBits)
	) DUT (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores)
	);

	always #10 clk = ~clk;

	// ========================================
	// Reference model
	// ========================================

	function automatic nnPkg::sampleT neuronOutput(input longint acc, input bit useRelu);
		longint scaled;
		scaled = acc >>> FracBits; // Floor
		if (scaled > sampleHigh)
			scaled = sampleHigh;
		else if (scaled < sampleLow)
			scaled = sampleLow;
		if (useRelu && scaled < 0)
			scaled = 0;
		return nnPkg::sampleT'(scaled);
	endfunction

	function automatic scorePackT referenceScores(input featurePackT f);
		hiddenPackT h;
		scorePackT s;
		longint acc;
		for (int n = 0; n < nnPkg::numHidden; n++)
		begin
			acc = longint'($signed(hiddenBiases[n])) * (longint'(1) << FracBits);
			for (int i = 0; i < nnPkg::numFeatures; i++)
				acc += longint'($signed(f[i]))
					* longint'($signed(hiddenWeights[n*nnPkg::numFeatures + i]));
			h[n] = neuronOutput(acc, 1'b1);
		end
		for (int n = 0; n < nnPkg::numScores; n++)
		begin
			acc = longint'($signed(scoreBiases[n])) * (longint'(1) << FracBits);
			for (int i = 0; i < nnPkg::numHidden; i++)
				acc += longint'($signed(h[i]))
					* longint'($signed(scoreWeights[n*nnPkg::numHidden + i]));
			s[n] = neuronOutput(acc, 1'b0); // Linear scores
		end
		return s;
	endfunction

	// ========================================
	// Helpers
	// ========================================

	task automatic checkValue(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual)
		begin
			errorCount++;
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	task automatic applyVector(input featurePackT vec, input string name);
		@(posedge clk);
		#1;
		currentVector = vec;
		currentName = name;
		for (int i = 0; i < nnPkg::numFeatures; i++)
			features[i] = vec[i];
	endtask

	function automatic featurePackT uniformVector(input nnPkg::sampleT value);
		featurePackT vec;
		for (int i = 0; i < nnPkg::numFeatures; i++)
			vec[i] = value;
		return vec;
	endfunction

	// Mostly within +-4.0, with an occasional full scale vector
	task automatic randomVector(output featurePackT vec, input bit fullScale);
		for (int i = 0; i < nnPkg::numFeatures; i++)
		begin
			if (fullScale)
				vec[i] = nnPkg::sampleT'($random(seed));
			else
				vec[i] = nnPkg::sampleT'($random(seed) % 1024);
		end
	endtask

	task automatic waitForCheck(input int serial);
		int cycles;
		cycles = 0;
		while (lastChecked < serial)
		begin
			@(negedge clk);
			#1;
			cycles++;
			if (lastChecked < serial && cycles > drainTimeout)
			begin
				$display("Timeout: vector %0d was never compared with the scores", serial);
				$display("FAIL: see errors above");
				$fatal(1, "Drain timeout");
			end
		end
	endtask

	// ========================================
	// Delay line and comparison
	// ========================================

	always @(negedge clk)
	begin : compare
		scorePackT expected;
		string name;
		if (reset)
		begin
			if (resetSeen) // Reset has reached the registers
			begin
				for (int s = 0; s < nnPkg::numScores; s++)
					checkValue($sformatf("reset held score %0d", s), 0, scores[s]);
			end
			expectedLine.delete();
			nameLine.delete();
			serialLine.delete();
			resetSeen = 1'b1;
		end
		else
		begin
			resetSeen = 1'b0;
			pushCount++;
			expectedLine.push_back(referenceScores(currentVector));
			nameLine.push_back(currentName);
			serialLine.push_back(pushCount);
			if (expectedLine.size() > nnPkg::netLatency)
			begin
				expected = expectedLine.pop_front();
				name = nameLine.pop_front();
				lastChecked = serialLine.pop_front();
				for (int s = 0; s < nnPkg::numScores; s++)
					checkValue($sformatf("%s score %0d", name, s), expected[s], scores[s]);
			end
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	initial
	begin
		featurePackT vec;
		clk = 1'b0;
		reset = 1'b1;
		seed = 32'he6f3;
		currentVector = '0;
		currentName = "reset";
		pushCount = 0;
		lastChecked = 0;
		resetSeen = 1'b0;
		errorCount = 0;
		for (int i = 0; i < nnPkg::numFeatures; i++)
			features[i] = '0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (3) applyVector('0, "zero input"); // Biases only

		// Hidden sums pushed negative
		applyVector(uniformVector(-16'sd256), "relu uniform");
		applyVector({-16'sd512, 16'sd512, -16'sd512, -16'sd512,
			16'sd512, -16'sd512, -16'sd512, 16'sd512}, "relu neuron 0");
		applyVector({-16'sd384, -16'sd384, 16'sd384, 16'sd384,
			-16'sd384, -16'sd384, 16'sd384, -16'sd384}, "relu neuron 2");

		applyVector(uniformVector(16'sh7fff), "saturation max");
		applyVector(uniformVector(16'sh8000), "saturation min");
		applyVector({16'sh7fff, 16'sh8000, 16'sh7fff, 16'sh7fff,
			16'sh8000, 16'sh7fff, 16'sh7fff, 16'sh8000}, "saturation mixed");
		// Hidden 0 and 2 at the top, 1 and 3 clipped, score 1 clamps low
		applyVector({16'sh7fff, 16'sh7fff, 16'sh0000, 16'sh8000,
			16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sh7fff}, "saturation score min");

		for (int i = 0; i < 300; i++)
		begin
			randomVector(vec, (i % 16) == 15);
			applyVector(vec, "streaming");
		end

		for (int i = 0; i < 60; i++)
		begin
			randomVector(vec, 1'b0);
			applyVector(vec, "reset mid-stream");
			if (i == 20)
				reset = 1'b1;
			else if (i == 26)
				reset = 1'b0;
		end

		// Last vector gets its serial at the next falling edge
		@(negedge clk);
		#1;
		waitForCheck(pushCount);

		if (errorCount == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
		begin
			$display("FAIL: see errors above");
			$fatal(1, "Errors found");
		end
	end

endmodule

// File: sources.f
+incdir+include
src/nnPkg.sv
src/macTree.sv
src/activation.sv
src/denseLayer.sv
src/mlpTop.sv
tb/mlpTb.sv

// File: Bender.yml
package:
  name: mlp_engine

sources:
  - include_dirs:
      - include
    files:
      - src/nnPkg.sv
      - src/macTree.sv
      - src/activation.sv
      - src/denseLayer.sv
      - src/mlpTop.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/mlpTb.sv
